/* bench/simple_dma_props.sv */
module simple_dma_props
  import dma_pkg::*;
(
  input logic Bus2IP_Clk,
  input logic rst_n,
  input logic ip2bus_mstrd_req,
  input logic ip2bus_mstwr_req,
  input logic dma_done,
  input logic fifo_full,
  input logic fifo_empty
);

  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions, read back by the testbench top
  int unsigned assert_errs = 0;

  // --------------------------------------------------
  // master port
  // --------------------------------------------------
  // single-beat engine, one direction at a time
  a_one_req: assert property (@(posedge Bus2IP_Clk) disable iff (!rst_n)
    !(ip2bus_mstrd_req && ip2bus_mstwr_req))
  else
  begin
    assert_errs++;
    $error("read and write requests are high together");
  end

  // end of copy is a single-cycle pulse
  a_done_pulse: assert property (@(posedge Bus2IP_Clk) disable iff (!rst_n)
    dma_done |=> !dma_done)
  else
  begin
    assert_errs++;
    $error("dma_done stayed high for more than one cycle");
  end

  // --------------------------------------------------
  // fifo flags
  // --------------------------------------------------
  a_fifo_flags: assert property (@(posedge Bus2IP_Clk) disable iff (!rst_n)
    !(fifo_full && fifo_empty))
  else
  begin
    assert_errs++;
    $error("fifo reports full and empty at once");
  end

endmodule

bind simple_dma simple_dma_props i_props (
  .Bus2IP_Clk       (Bus2IP_Clk),
  .rst_n            (rst_n),
  .ip2bus_mstrd_req (ip2bus_mstrd_req),
  .ip2bus_mstwr_req (ip2bus_mstwr_req),
  .dma_done         (dma_done),
  .fifo_full        (fifo_full),
  .fifo_empty       (fifo_empty)
);

/* bench/tb_clk_gen.sv */
module tb_clk_gen
(
  output logic Bus2IP_Clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial
  begin
    Bus2IP_Clk = 1'b0;
    forever
      #2 Bus2IP_Clk = ~Bus2IP_Clk;
  end

  // reset held low for 5 rising edges, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (5) @(posedge Bus2IP_Clk);
    @(negedge Bus2IP_Clk);
    rst_n = 1'b1;
  end

endmodule

/* bench/tb_simple_dma.sv */
module tb_simple_dma
  import dma_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // xor mask of the memory model read data
  localparam data_t RD_MASK    = 32'ha5a5_0000;
  localparam int    WAIT_LIMIT = 4000;

  logic    Bus2IP_Clk;
  logic    rst_n;
  data_t   bus2ip_data;
  ce_t     bus2ip_wrce;
  ce_t     bus2ip_rdce;
  data_t   ip2bus_data;
  logic    ip2bus_wrack;
  logic    ip2bus_rdack;
  logic    ip2bus_mstrd_req;
  logic    ip2bus_mstwr_req;
  addr_t   ip2bus_mst_addr;
  logic    bus2ip_mst_cmdack;
  logic    bus2ip_mst_cmplt;
  logic    bus2ip_mst_error;
  logic    bus2ip_mst_cmd_timeout;
  data_t   bus2ip_mstrd_d;
  logic    bus2ip_mstrd_src_rdy_n;
  data_t   ip2bus_mstwr_d;
  logic    bus2ip_mstwr_dst_rdy_n;
  logic    dma_done;

  // logs kept by the memory model, only ever appended
  addr_t   rd_addr_log[$];
  addr_t   wr_addr_log[$];
  data_t   wr_data_log[$];
  cmd_op_e op_log[$];
  int      beat_cnt;
  int      done_cnt;
  // beat number that gets an error or timeout response, -1 when disarmed
  int      err_beat;
  int      tmo_beat;
  // log positions at the start of the current copy
  int      rd_base;
  int      wr_base;
  int      op_base;
  int      done_base;
  int      err_cnt;

  tb_clk_gen u_clk (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst_n      (rst_n)
  );

  simple_dma i_dut (.*);

  // --------------------------------------------------
  // bus-slave memory model
  // --------------------------------------------------
  initial
  begin : bus_model
    int unsigned delay;
    addr_t       addr;
    logic        is_read;
    void'($urandom(32'h018c_e061));
    bus2ip_mst_cmdack      = 1'b0;
    bus2ip_mst_cmplt       = 1'b0;
    bus2ip_mst_error       = 1'b0;
    bus2ip_mst_cmd_timeout = 1'b0;
    bus2ip_mstrd_d         = '0;
    bus2ip_mstrd_src_rdy_n = 1'b1;
    bus2ip_mstwr_dst_rdy_n = 1'b1;
    beat_cnt               = 0;
    forever
    begin
      @(negedge Bus2IP_Clk);
      if (rst_n && (ip2bus_mstrd_req || ip2bus_mstwr_req))
      begin
        addr    = ip2bus_mst_addr;
        is_read = ip2bus_mstrd_req;
        // stall with the request held high
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge Bus2IP_Clk);
        // sometimes accept the command before completing it
        if ($urandom_range(1, 0) == 1)
        begin
          bus2ip_mst_cmdack = 1'b1;
          @(negedge Bus2IP_Clk);
          bus2ip_mst_cmdack = 1'b0;
        end
        bus2ip_mst_cmplt       = 1'b1;
        bus2ip_mst_error       = (beat_cnt == err_beat);
        bus2ip_mst_cmd_timeout = (beat_cnt == tmo_beat);
        if (is_read)
        begin
          bus2ip_mstrd_d         = addr ^ RD_MASK;
          bus2ip_mstrd_src_rdy_n = 1'b0;
          rd_addr_log.push_back(addr);
        end
        else
        begin
          bus2ip_mstwr_dst_rdy_n = 1'b0;
          wr_addr_log.push_back(addr);
          wr_data_log.push_back(ip2bus_mstwr_d);
        end
        op_log.push_back(is_read ? OP_READ : OP_WRITE);
        beat_cnt++;
        @(negedge Bus2IP_Clk);
        bus2ip_mst_cmplt       = 1'b0;
        bus2ip_mst_error       = 1'b0;
        bus2ip_mst_cmd_timeout = 1'b0;
        bus2ip_mstrd_src_rdy_n = 1'b1;
        bus2ip_mstwr_dst_rdy_n = 1'b1;
      end
    end
  end

  // dma_done pulses seen over the whole run
  initial
  begin
    done_cnt = 0;
    forever
    begin
      @(negedge Bus2IP_Clk);
      if (dma_done === 1'b1)
        done_cnt++;
    end
  end

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // run control
  // --------------------------------------------------
  task automatic finish_run();
    int total;
    total = err_cnt + int'(i_dut.i_props.assert_errs);
    $display("errors: %0d failed checks, %0d failed assertions",
             err_cnt, i_dut.i_props.assert_errs);
    if (total == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  endtask

  task automatic report_timeout(input string what, input int limit);
    err_cnt++;
    $display("timeout: the wait for %s did not finish within %0d cycles", what, limit);
    finish_run();
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 20)
    begin
      @(negedge Bus2IP_Clk);
      n++;
    end
    if (rst_n !== 1'b1)
      report_timeout("reset release", 20);
  endtask

  task automatic wait_done(input int limit);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit)
    begin
      @(negedge Bus2IP_Clk);
      seen = (dma_done === 1'b1);
      n++;
    end
    if (!seen)
      report_timeout("dma_done", limit);
  endtask

  // --------------------------------------------------
  // register port access
  // --------------------------------------------------
  // msb of the chip-enable vector is register 0
  function automatic ce_t reg_ce(input int idx);
    return ce_t'(1) << (NUM_CE - 1 - idx);
  endfunction

  task automatic reg_write(input int idx, input data_t val);
    @(negedge Bus2IP_Clk);
    bus2ip_data = val;
    bus2ip_wrce = reg_ce(idx);
    #1;
    check_bit($sformatf("wrack of register %0d", idx), ip2bus_wrack, 1'b1);
    @(negedge Bus2IP_Clk);
    bus2ip_wrce = '0;
  endtask

  task automatic reg_read(input int idx, output data_t val);
    @(negedge Bus2IP_Clk);
    bus2ip_rdce = reg_ce(idx);
    #1;
    check_bit($sformatf("rdack of register %0d", idx), ip2bus_rdack, 1'b1);
    val = ip2bus_data;
    @(negedge Bus2IP_Clk);
    bus2ip_rdce = '0;
  endtask

  // status word as laid out for register 4
  function automatic data_t status_word(input logic tmo, input logic err,
                                        input logic empty, input logic full,
                                        input seq_state_e st);
    data_t w;
    w      = '0;
    w[1:0] = st;
    w[2]   = full;
    w[3]   = empty;
    w[4]   = err;
    w[5]   = tmo;
    return w;
  endfunction

  task automatic check_status(input string what, input data_t exp);
    data_t val;
    reg_read(REG_STATUS, val);
    check_data(what, val, exp);
  endtask

  // --------------------------------------------------
  // copy helpers
  // --------------------------------------------------
  task automatic start_copy(input addr_t src, input addr_t dst, input data_t len);
    rd_base   = rd_addr_log.size();
    wr_base   = wr_addr_log.size();
    op_base   = op_log.size();
    done_base = done_cnt;
    reg_write(REG_SRC, src);
    reg_write(REG_DST, dst);
    reg_write(REG_LEN, len);
    reg_write(REG_GO, GO_KEY);
  endtask

  // addresses, data and round order of the last copy
  task automatic check_copy(input addr_t src, input addr_t dst, input int nwords);
    cmd_op_e exp_ops[$];
    int      left;
    int      r;
    addr_t   a;
    check_count("read beats", rd_addr_log.size() - rd_base, nwords);
    check_count("write beats", wr_addr_log.size() - wr_base, nwords);
    for (int k = 0; k < nwords && rd_base + k < rd_addr_log.size(); k++)
    begin
      a = src + addr_t'(k * WORD_BYTES);
      check_addr($sformatf("read %0d address", k), rd_addr_log[rd_base + k], a);
    end
    for (int k = 0; k < nwords && wr_base + k < wr_addr_log.size(); k++)
    begin
      a = dst + addr_t'(k * WORD_BYTES);
      check_addr($sformatf("write %0d address", k), wr_addr_log[wr_base + k], a);
      a = src + addr_t'(k * WORD_BYTES);
      check_data($sformatf("write %0d data", k), wr_data_log[wr_base + k], a ^ RD_MASK);
    end
    // each round fills up to a fifo of reads, then drains it
    left = nwords;
    while (left > 0)
    begin
      r = (left > FIFO_DEPTH) ? FIFO_DEPTH : left;
      repeat (r) exp_ops.push_back(OP_READ);
      repeat (r) exp_ops.push_back(OP_WRITE);
      left -= r;
    end
    for (int k = 0; k < exp_ops.size() && op_base + k < op_log.size(); k++)
      check_bit($sformatf("beat %0d is a write", k), op_log[op_base + k] == OP_WRITE,
                exp_ops[k] == OP_WRITE);
  endtask

  task automatic finish_copy(input string name, input int nwords);
    wait_done(WAIT_LIMIT);
    // every beat of the copy is on the bus before the end pulse
    check_count({name, " read beats before dma_done"},
                rd_addr_log.size() - rd_base, nwords);
    check_count({name, " write beats before dma_done"},
                wr_addr_log.size() - wr_base, nwords);
    repeat (10) @(negedge Bus2IP_Clk);
    check_count({name, " dma_done pulses"}, done_cnt - done_base, 1);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reg_access();
    data_t val;
    check_bit("read request after reset", ip2bus_mstrd_req, 1'b0);
    check_bit("write request after reset", ip2bus_mstwr_req, 1'b0);
    check_bit("dma_done after reset", dma_done, 1'b0);
    reg_write(REG_SRC, 32'h1234_5678);
    reg_write(REG_DST, 32'h9abc_def0);
    reg_write(REG_LEN, 32'h0000_0040);
    reg_read(REG_SRC, val);
    check_data("source register", val, 32'h1234_5678);
    reg_read(REG_DST, val);
    check_data("destination register", val, 32'h9abc_def0);
    reg_read(REG_LEN, val);
    check_data("length register", val, 32'h0000_0040);
    for (int i = 5; i < NUM_CE; i++)
    begin
      // unused chip enables are acked but hold nothing
      reg_write(i, 32'hffff_ffff);
      reg_read(i, val);
      check_data($sformatf("unused register %0d", i), val, '0);
    end
    check_status("status after reset", status_word(1'b0, 1'b0, 1'b1, 1'b0, SEQ_IDLE));
  endtask

  task automatic test_long_copy();
    // 128 bytes is two full fifo rounds
    start_copy(32'h0000_1000, 32'h0004_0000, 32'd128);
    finish_copy("long copy", 32);
    check_copy(32'h0000_1000, 32'h0004_0000, 32);
    check_status("status after long copy", status_word(1'b0, 1'b0, 1'b1, 1'b0, SEQ_IDLE));
  endtask

  task automatic test_short_copy();
    start_copy(32'h0000_2100, 32'h0005_0000, 32'd12);
    finish_copy("short copy", 3);
    check_copy(32'h0000_2100, 32'h0005_0000, 3);
  endtask

  task automatic test_bad_key();
    int    hits;
    data_t val;
    hits      = 0;
    done_base = done_cnt;
    reg_write(REG_SRC, 32'h0000_3000);
    reg_write(REG_DST, 32'h0006_0000);
    reg_write(REG_LEN, 32'd16);
    reg_write(REG_GO, 32'h0000_0055);
    repeat (50)
    begin
      @(negedge Bus2IP_Clk);
      if (ip2bus_mstrd_req || ip2bus_mstwr_req)
        hits++;
    end
    check_count("request cycles after a wrong go value", hits, 0);
    check_count("dma_done pulses after a wrong go value", done_cnt - done_base, 0);
    // value other than the key stays in the go register
    reg_read(REG_GO, val);
    check_data("go register", val, 32'h0000_0055);
  endtask

  task automatic test_error_response();
    // error on the second read beat, the copy goes on
    err_beat = beat_cnt + 1;
    start_copy(32'h0000_4000, 32'h0007_0000, 32'd12);
    finish_copy("error copy", 3);
    check_copy(32'h0000_4000, 32'h0007_0000, 3);
    check_status("status after error", status_word(1'b0, 1'b1, 1'b1, 1'b0, SEQ_IDLE));
    err_beat = -1;
    // timeout on the second write beat
    tmo_beat = beat_cnt + 4;
    start_copy(32'h0000_5000, 32'h0008_0000, 32'd12);
    finish_copy("timeout copy", 3);
    check_copy(32'h0000_5000, 32'h0008_0000, 3);
    check_status("status after timeout", status_word(1'b1, 1'b1, 1'b1, 1'b0, SEQ_IDLE));
    tmo_beat = -1;
    // clean copy clears both sticky bits
    start_copy(32'h0000_6000, 32'h0009_0000, 32'd8);
    finish_copy("clean copy", 2);
    check_copy(32'h0000_6000, 32'h0009_0000, 2);
    check_status("status after new go", status_word(1'b0, 1'b0, 1'b1, 1'b0, SEQ_IDLE));
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    bus2ip_data = '0;
    bus2ip_wrce = '0;
    bus2ip_rdce = '0;
    err_beat    = -1;
    tmo_beat    = -1;
    err_cnt     = 0;
    rd_base     = 0;
    wr_base     = 0;
    op_base     = 0;
    done_base   = 0;
    wait_reset();
    test_reg_access();
    test_long_copy();
    test_short_copy();
    test_bad_key();
    test_error_response();
    finish_run();
  end

endmodule

/* hdl/data_fifo.sv */
module data_fifo
  import dma_pkg::*;
(
  input  logic  Bus2IP_Clk,
  input  logic  rst_n,
  input  logic  push,
  input  data_t push_data,
  input  logic  pop,
  output data_t head,
  output logic  fifo_full,
  output logic  fifo_empty
);

  data_t              mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  // one extra bit so a full buffer is distinct from an empty one
  logic [FIFO_AW:0]   count;
  logic               do_push;
  logic               do_pop;

  // overflow and underflow attempts are dropped
  assign do_push = push && !fifo_full;
  assign do_pop  = pop && !fifo_empty;

  assign fifo_full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign fifo_empty = (count == '0);
  // head is always presented, valid when not empty
  assign head       = mem[rd_ptr];

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // push and pop together leave the count alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

/* hdl/dma_pkg.sv */
package dma_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  // byte step per word, used for both addresses and length
  localparam int WORD_BYTES = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // --------------------------------------------------
  // register slave port
  // --------------------------------------------------
  localparam int NUM_CE = 8;
  typedef logic [NUM_CE-1:0] ce_t;

  // register indices, msb of the chip-enable vector selects register 0
  localparam int REG_SRC    = 0;
  localparam int REG_DST    = 1;
  localparam int REG_LEN    = 2;
  localparam int REG_GO     = 3;
  localparam int REG_STATUS = 4;
  // indices 5..7 are unused and read as zero

  // value the driver writes to the go register to start a copy
  localparam data_t GO_KEY = 32'h0000_00cc;

  // --------------------------------------------------
  // data fifo
  // --------------------------------------------------
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // status word (register 4)
  //   [1:0] sequencer state
  //   [2]   fifo full
  //   [3]   fifo empty
  //   [4]   sticky error
  //   [5]   sticky timeout
  //   rest  zero
  typedef enum logic [1:0] {SEQ_IDLE, SEQ_READ, SEQ_WRITE} seq_state_e;

  // single-beat master command fsm
  typedef enum logic [1:0] {CMD_IDLE, CMD_RUN, CMD_WAIT_DATA, CMD_DONE} cmd_state_e;
  typedef enum logic {OP_READ, OP_WRITE} cmd_op_e;

endpackage

/* hdl/dma_regs.sv */
module dma_regs
  import dma_pkg::*;
(
  input  logic  Bus2IP_Clk,
  input  logic  rst_n,
  input  data_t bus2ip_data,
  input  ce_t   bus2ip_wrce,
  input  ce_t   bus2ip_rdce,
  input  data_t seq_status,
  output data_t ip2bus_data,
  output logic  ip2bus_wrack,
  output logic  ip2bus_rdack,
  output addr_t src_addr,
  output addr_t dst_addr,
  output data_t length,
  output logic  go
);

  // chip enables bit-reversed so that sel[i] selects register i
  ce_t   wr_sel;
  ce_t   rd_sel;
  // go register, self clearing once it holds the key
  data_t go_reg;
  data_t rd_mux;

  assign wr_sel = {<<{bus2ip_wrce}};
  assign rd_sel = {<<{bus2ip_rdce}};

  // --------------------------------------------------
  // acks
  // --------------------------------------------------
  // every chip enable is acked in its own strobe cycle, no wait states
  assign ip2bus_wrack = |bus2ip_wrce;
  assign ip2bus_rdack = |bus2ip_rdce;

  // start pulse, high for the one cycle the key sits in the register
  assign go = (go_reg == GO_KEY);

  // --------------------------------------------------
  // register writes
  // --------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n)
    begin
      src_addr <= '0;
      dst_addr <= '0;
      length   <= '0;
      go_reg   <= '0;
    end
    else
    begin
      if (wr_sel[REG_SRC])
        src_addr <= bus2ip_data;
      if (wr_sel[REG_DST])
        dst_addr <= bus2ip_data;
      if (wr_sel[REG_LEN])
        length <= bus2ip_data;
      // a fresh write wins over the clear
      if (wr_sel[REG_GO])
        go_reg <= bus2ip_data;
      else if (go)
        go_reg <= '0;
      // a value other than the key just stays put and starts nothing
    end
  end

  // --------------------------------------------------
  // read mux
  // --------------------------------------------------
  // falls through to zero when no chip enable is set, so the bus sees
  // zero outside the ack cycle and for registers 5..7
  always_comb
  begin
    rd_mux = '0;
    if (rd_sel[REG_SRC])
      rd_mux = src_addr;
    else if (rd_sel[REG_DST])
      rd_mux = dst_addr;
    else if (rd_sel[REG_LEN])
      rd_mux = length;
    else if (rd_sel[REG_GO])
      rd_mux = go_reg;
    else if (rd_sel[REG_STATUS])
      rd_mux = seq_status;
  end

  assign ip2bus_data = rd_mux;

endmodule

/* hdl/dma_sequencer.sv */
module dma_sequencer
  import dma_pkg::*;
(
  input  logic    Bus2IP_Clk,
  input  logic    rst_n,
  input  logic    go,
  input  addr_t   src_addr,
  input  addr_t   dst_addr,
  input  data_t   length,
  input  logic    fifo_full,
  input  logic    fifo_empty,
  input  logic    cmd_busy,
  input  logic    cmd_done,
  input  logic    cmd_error,
  input  logic    cmd_timeout,
  output logic    cmd_start,
  output cmd_op_e cmd_op,
  output addr_t   cmd_addr,
  output data_t   seq_status,
  output logic    dma_done
);

  seq_state_e state;
  // working copies of the programmed registers
  addr_t      src_cnt;
  addr_t      dst_cnt;
  data_t      len_cnt;
  // one command in flight, set on start and cleared on done
  logic       pending;
  logic       err_s;
  logic       tmo_s;
  logic       issue_rd;
  logic       issue_wr;

  // --------------------------------------------------
  // command issue conditions
  // --------------------------------------------------
  // read while the fifo has room and bytes are left
  assign issue_rd = (state == SEQ_READ) && !pending && !cmd_busy &&
                    !fifo_full && (len_cnt != '0);
  // write until the fifo drains
  assign issue_wr = (state == SEQ_WRITE) && !pending && !cmd_busy && !fifo_empty;

  assign seq_status = {{(DATA_W-6){1'b0}}, tmo_s, err_s, fifo_empty, fifo_full, state};

  // working counters and command payload
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (state == SEQ_IDLE && go)
    begin
      src_cnt <= src_addr;
      dst_cnt <= dst_addr;
      len_cnt <= length;
    end
    else if (cmd_done && state == SEQ_READ)
    begin
      src_cnt <= src_cnt + addr_t'(WORD_BYTES);
      // saturate so an odd length still ends at zero
      len_cnt <= (len_cnt > data_t'(WORD_BYTES)) ? len_cnt - data_t'(WORD_BYTES) : '0;
    end
    else if (cmd_done && state == SEQ_WRITE)
      dst_cnt <= dst_cnt + addr_t'(WORD_BYTES);

    if (issue_rd)
    begin
      cmd_op   <= OP_READ;
      cmd_addr <= src_cnt;
    end
    else if (issue_wr)
    begin
      cmd_op   <= OP_WRITE;
      cmd_addr <= dst_cnt;
    end
  end

  // --------------------------------------------------
  // round control
  // --------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n)
    begin
      state     <= SEQ_IDLE;
      pending   <= 1'b0;
      cmd_start <= 1'b0;
      dma_done  <= 1'b0;
      err_s     <= 1'b0;
      tmo_s     <= 1'b0;
    end
    else
    begin
      cmd_start <= issue_rd | issue_wr;
      dma_done  <= 1'b0;
      if (issue_rd | issue_wr)
        pending <= 1'b1;
      // responses are only recorded, the copy carries on
      if (cmd_done)
      begin
        pending <= 1'b0;
        err_s   <= err_s | cmd_error;
        tmo_s   <= tmo_s | cmd_timeout;
      end
      case (state)
        SEQ_IDLE:
          if (go)
          begin
            state <= SEQ_READ;
            err_s <= 1'b0;
            tmo_s <= 1'b0;
          end
        SEQ_READ:
          // fifo flags are settled once the last command has retired
          if (!pending && (fifo_full || len_cnt == '0))
            state <= SEQ_WRITE;
        SEQ_WRITE:
          if (!pending && fifo_empty)
          begin
            if (len_cnt == '0)
            begin
              state    <= SEQ_IDLE;
              dma_done <= 1'b1;
            end
            else
              state <= SEQ_READ;
          end
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

/* hdl/mst_cmd_fsm.sv */
module mst_cmd_fsm
  import dma_pkg::*;
(
  input  logic    Bus2IP_Clk,
  input  logic    rst_n,
  input  logic    cmd_start,
  input  cmd_op_e cmd_op,
  input  addr_t   cmd_addr,
  input  logic    bus2ip_mst_cmdack,
  input  logic    bus2ip_mst_cmplt,
  input  logic    bus2ip_mst_error,
  input  logic    bus2ip_mst_cmd_timeout,
  output logic    ip2bus_mstrd_req,
  output logic    ip2bus_mstwr_req,
  output addr_t   ip2bus_mst_addr,
  output logic    cmd_busy,
  output logic    cmd_done,
  output logic    cmd_error,
  output logic    cmd_timeout
);

  cmd_state_e state;
  // command captured at start
  cmd_op_e    op_r;
  addr_t      addr_r;

  // busy from the cycle after start until the cycle after done
  assign cmd_busy = (state != CMD_IDLE);
  assign cmd_done = (state == CMD_DONE);

  // --------------------------------------------------
  // command payload
  // --------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (state == CMD_IDLE && cmd_start)
    begin
      op_r   <= cmd_op;
      addr_r <= cmd_addr;
    end
    // address goes out alongside the registered request
    if (state == CMD_RUN)
      ip2bus_mst_addr <= addr_r;
  end

  // --------------------------------------------------
  // command state machine
  // --------------------------------------------------
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (!rst_n)
    begin
      state            <= CMD_IDLE;
      ip2bus_mstrd_req <= 1'b0;
      ip2bus_mstwr_req <= 1'b0;
      cmd_error        <= 1'b0;
      cmd_timeout      <= 1'b0;
    end
    else
    begin
      // requests drop unless re-armed in CMD_RUN
      ip2bus_mstrd_req <= 1'b0;
      ip2bus_mstwr_req <= 1'b0;
      case (state)
        CMD_IDLE:
          if (cmd_start)
          begin
            state       <= CMD_RUN;
            cmd_error   <= 1'b0;
            cmd_timeout <= 1'b0;
          end
        CMD_RUN:
          // cmplt may arrive with or without a cmdack first
          if (bus2ip_mst_cmplt)
          begin
            state       <= CMD_DONE;
            // a timeout counts as an error as well
            cmd_error   <= bus2ip_mst_error | bus2ip_mst_cmd_timeout;
            cmd_timeout <= bus2ip_mst_cmd_timeout;
          end
          else if (bus2ip_mst_cmdack)
            state <= CMD_WAIT_DATA;
          else
          begin
            ip2bus_mstrd_req <= (op_r == OP_READ);
            ip2bus_mstwr_req <= (op_r == OP_WRITE);
          end
        CMD_WAIT_DATA:
          if (bus2ip_mst_cmplt)
          begin
            state       <= CMD_DONE;
            cmd_error   <= bus2ip_mst_error | bus2ip_mst_cmd_timeout;
            cmd_timeout <= bus2ip_mst_cmd_timeout;
          end
        CMD_DONE:
          state <= CMD_IDLE;
        default:
          state <= CMD_IDLE;
      endcase
    end
  end

endmodule

/* hdl/simple_dma.sv */
module simple_dma
  import dma_pkg::*;
(
  input  logic  Bus2IP_Clk,
  input  logic  rst_n,
  // register slave port
  input  data_t bus2ip_data,
  input  ce_t   bus2ip_wrce,
  input  ce_t   bus2ip_rdce,
  output data_t ip2bus_data,
  output logic  ip2bus_wrack,
  output logic  ip2bus_rdack,
  // master command port
  output logic  ip2bus_mstrd_req,
  output logic  ip2bus_mstwr_req,
  output addr_t ip2bus_mst_addr,
  input  logic  bus2ip_mst_cmdack,
  input  logic  bus2ip_mst_cmplt,
  input  logic  bus2ip_mst_error,
  input  logic  bus2ip_mst_cmd_timeout,
  // master data
  input  data_t bus2ip_mstrd_d,
  input  logic  bus2ip_mstrd_src_rdy_n,
  output data_t ip2bus_mstwr_d,
  input  logic  bus2ip_mstwr_dst_rdy_n,
  // end of copy
  output logic  dma_done
);

  addr_t   src_addr;
  addr_t   dst_addr;
  data_t   length;
  logic    go;
  data_t   seq_status;
  logic    cmd_start;
  cmd_op_e cmd_op;
  addr_t   cmd_addr;
  logic    cmd_busy;
  logic    cmd_done;
  logic    cmd_error;
  logic    cmd_timeout;
  logic    fifo_full;
  logic    fifo_empty;
  logic    push;
  logic    pop;

  // --------------------------------------------------
  // fifo strobes from the active-low ready lines
  // --------------------------------------------------
  // read data lands in the fifo, write data leaves from its head
  assign push = ~bus2ip_mstrd_src_rdy_n;
  assign pop  = ~bus2ip_mstwr_dst_rdy_n;

  dma_regs u_regs (
    .Bus2IP_Clk   (Bus2IP_Clk),
    .rst_n        (rst_n),
    .bus2ip_data  (bus2ip_data),
    .bus2ip_wrce  (bus2ip_wrce),
    .bus2ip_rdce  (bus2ip_rdce),
    .seq_status   (seq_status),
    .ip2bus_data  (ip2bus_data),
    .ip2bus_wrack (ip2bus_wrack),
    .ip2bus_rdack (ip2bus_rdack),
    .src_addr     (src_addr),
    .dst_addr     (dst_addr),
    .length       (length),
    .go           (go)
  );

  dma_sequencer u_seq (
    .Bus2IP_Clk  (Bus2IP_Clk),
    .rst_n       (rst_n),
    .go          (go),
    .src_addr    (src_addr),
    .dst_addr    (dst_addr),
    .length      (length),
    .fifo_full   (fifo_full),
    .fifo_empty  (fifo_empty),
    .cmd_busy    (cmd_busy),
    .cmd_done    (cmd_done),
    .cmd_error   (cmd_error),
    .cmd_timeout (cmd_timeout),
    .cmd_start   (cmd_start),
    .cmd_op      (cmd_op),
    .cmd_addr    (cmd_addr),
    .seq_status  (seq_status),
    .dma_done    (dma_done)
  );

  mst_cmd_fsm u_cmd (
    .Bus2IP_Clk             (Bus2IP_Clk),
    .rst_n                  (rst_n),
    .cmd_start              (cmd_start),
    .cmd_op                 (cmd_op),
    .cmd_addr               (cmd_addr),
    .bus2ip_mst_cmdack      (bus2ip_mst_cmdack),
    .bus2ip_mst_cmplt       (bus2ip_mst_cmplt),
    .bus2ip_mst_error       (bus2ip_mst_error),
    .bus2ip_mst_cmd_timeout (bus2ip_mst_cmd_timeout),
    .ip2bus_mstrd_req       (ip2bus_mstrd_req),
    .ip2bus_mstwr_req       (ip2bus_mstwr_req),
    .ip2bus_mst_addr        (ip2bus_mst_addr),
    .cmd_busy               (cmd_busy),
    .cmd_done               (cmd_done),
    .cmd_error              (cmd_error),
    .cmd_timeout            (cmd_timeout)
  );

  data_fifo u_fifo (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_data  (bus2ip_mstrd_d),
    .pop        (pop),
    .head       (ip2bus_mstwr_d),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

endmodule

/* tb.f */
hdl/dma_pkg.sv
hdl/dma_regs.sv
hdl/dma_sequencer.sv
hdl/mst_cmd_fsm.sv
hdl/data_fifo.sv
hdl/simple_dma.sv
bench/simple_dma_props.sv
bench/tb_clk_gen.sv
bench/tb_simple_dma.sv
